//--- src/cluster_pkg.sv
////////////////////////////////////////
// Shared sizes, types and command formats for the
// vector cluster slice system. Referenced by scoped names
////////////////////////////////////////

package cluster_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int NrClusters = 4;
  // Fork tree depth, log2 of the cluster count
  localparam int NrLevels   = 2;
  localparam int ElemWidth  = 32;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [ElemWidth-1:0] elem_t;
  typedef logic [1:0]           cluster_id_t;

  typedef enum logic [1:0] {
    CMD_WRITE,
    CMD_READ,
    CMD_SLIDE_UP,
    CMD_SLIDE_DOWN
  } cmd_op_e;

  // Host command, broadcast unchanged to every slice
  typedef struct packed {
    cmd_op_e     op;
    cluster_id_t id;
    elem_t       data;
  } cmd_t;

  typedef struct packed {
    elem_t data;
  } rsp_t;

  // Per slice completion, data is zero unless addressed read
  typedef struct packed {
    logic  done;
    elem_t data;
  } ack_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT,
    ST_RESP
  } ctrl_state_e;

endpackage

//--- src/ring_spill.sv
////////////////////////////////////////
// Two slot spill register for one ring link.
// Both valid and ready leave from flops
////////////////////////////////////////

module ring_spill (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               valid_i,
  input  cluster_pkg::elem_t data_i,
  output logic               ready_o,
  output logic               valid_o,
  output cluster_pkg::elem_t data_o,
  input  logic               ready_i
);

  // Slot a drives the output, slot b catches a stalled push
  cluster_pkg::elem_t a_data_q, b_data_q;
  logic               a_full_q, b_full_q;
  logic               push;
  logic               a_load;

  assign ready_o = !b_full_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;
  assign push    = valid_i && ready_o;
  assign a_load  = push && (!a_full_q || ready_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (b_full_q) begin
      // Slot a refills from b, so it stays full
      if (ready_i) b_full_q <= 1'b0;
    end else if (push) begin
      if (a_full_q && !ready_i) b_full_q <= 1'b1;
      else a_full_q <= 1'b1;
    end else if (ready_i) begin
      a_full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (b_full_q && ready_i) begin
      a_data_q <= b_data_q;
    end else if (a_load) begin
      a_data_q <= data_i;
    end
    if (push && a_full_q && !ready_i) begin
      b_data_q <= data_i;
    end
  end

endmodule

//--- src/req_fork_tree.sv
////////////////////////////////////////
// Registered binary broadcast tree. One register per level,
// a node frees its slot once every child has its copy
////////////////////////////////////////

module req_fork_tree (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          valid_i,
  input  cluster_pkg::cmd_t                             cmd_i,
  output logic                                          ready_o,
  output logic [cluster_pkg::NrClusters-1:0]            valid_o,
  output cluster_pkg::cmd_t [cluster_pkg::NrClusters-1:0] cmd_o,
  input  logic [cluster_pkg::NrClusters-1:0]            ready_i
);

  // Heap numbering, node k feeds ports 2k+1 and 2k+2
  localparam int NrNodes = (1 << cluster_pkg::NrLevels) - 1;
  localparam int NrPorts = NrNodes + cluster_pkg::NrClusters;

  logic              port_valid [NrPorts];
  logic              port_ready [NrPorts];
  cluster_pkg::cmd_t port_cmd   [NrPorts];

  assign port_valid[0] = valid_i;
  assign port_cmd[0]   = cmd_i;
  assign ready_o       = port_ready[0];

  for (genvar k = 0; k < NrNodes; k++) begin : gen_node
    logic              valid_q;
    cluster_pkg::cmd_t cmd_q;
    logic [1:0]        taken_q;
    logic [1:0]        take;
    logic              all_taken;

    for (genvar c = 0; c < 2; c++) begin : gen_child
      assign port_valid[2*k+1+c] = valid_q && !taken_q[c];
      assign port_cmd[2*k+1+c]   = cmd_q;
      assign take[c]             = port_valid[2*k+1+c] && port_ready[2*k+1+c];
    end

    // Children may take their copies in different cycles
    assign all_taken     = &(taken_q | take);
    assign port_ready[k] = !valid_q || all_taken;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        valid_q <= 1'b0;
        taken_q <= '0;
      end else if (port_valid[k] && port_ready[k]) begin
        valid_q <= 1'b1;
        taken_q <= '0;
      end else if (valid_q && all_taken) begin
        valid_q <= 1'b0;
        taken_q <= '0;
      end else begin
        taken_q <= taken_q | take;
      end
    end

    always_ff @(posedge clk_i) begin
      if (port_valid[k] && port_ready[k]) begin
        cmd_q <= port_cmd[k];
      end
    end
  end

  // Leaf ports go straight to the slices
  for (genvar j = 0; j < cluster_pkg::NrClusters; j++) begin : gen_leaf
    assign valid_o[j]            = port_valid[NrNodes+j];
    assign cmd_o[j]              = port_cmd[NrNodes+j];
    assign port_ready[NrNodes+j] = ready_i[j];
  end

endmodule

//--- src/vector_slice.sv
////////////////////////////////////////
// One cluster slice holding a single vector element.
// Runs write, read and the ring slides, reports done
////////////////////////////////////////

module vector_slice #(
  parameter cluster_pkg::cluster_id_t ClusterId = '0
) (
  input  logic               clk_i,
  input  logic               rst_i,
  input  logic               cmd_valid_i,
  input  cluster_pkg::cmd_t  cmd_i,
  output logic               cmd_ready_o,
  output cluster_pkg::ack_t  ack_o,
  output logic               ring_r_valid_o,
  output cluster_pkg::elem_t ring_r_o,
  input  logic               ring_r_ready_i,
  output logic               ring_l_valid_o,
  output cluster_pkg::elem_t ring_l_o,
  input  logic               ring_l_ready_i,
  input  logic               ring_from_l_valid_i,
  input  cluster_pkg::elem_t ring_from_l_i,
  output logic               ring_from_l_ready_o,
  input  logic               ring_from_r_valid_i,
  input  cluster_pkg::elem_t ring_from_r_i,
  output logic               ring_from_r_ready_o
);

  cluster_pkg::elem_t elem_q, rx_q, rx_data;
  cluster_pkg::ack_t  ack_q;
  logic busy_q, up_q, send_pend_q, recv_done_q;
  logic accept, hit, is_slide, send_fire, recv_fire, finish;

  assign cmd_ready_o = !busy_q;
  assign accept      = cmd_valid_i && cmd_ready_o;
  assign hit         = (cmd_i.id == ClusterId);
  assign is_slide    = (cmd_i.op == cluster_pkg::CMD_SLIDE_UP) ||
                       (cmd_i.op == cluster_pkg::CMD_SLIDE_DOWN);
  assign ack_o       = ack_q;

  ////////////////////////////////////////
  // Ring handshakes
  ////////////////////////////////////////

  // Slide up sends right and receives from the left
  assign ring_r_valid_o      = busy_q && up_q && send_pend_q;
  assign ring_l_valid_o      = busy_q && !up_q && send_pend_q;
  assign ring_r_o            = elem_q;
  assign ring_l_o            = elem_q;
  assign ring_from_l_ready_o = busy_q && up_q && !recv_done_q;
  assign ring_from_r_ready_o = busy_q && !up_q && !recv_done_q;

  assign send_fire = (ring_r_valid_o && ring_r_ready_i) ||
                     (ring_l_valid_o && ring_l_ready_i);
  assign recv_fire = (ring_from_l_valid_i && ring_from_l_ready_o) ||
                     (ring_from_r_valid_i && ring_from_r_ready_o);
  assign rx_data   = !recv_fire ? rx_q : (up_q ? ring_from_l_i : ring_from_r_i);
  assign finish    = busy_q && (!send_pend_q || send_fire) && (recv_done_q || recv_fire);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      up_q        <= 1'b0;
      send_pend_q <= 1'b0;
      recv_done_q <= 1'b0;
      elem_q      <= '0;
      ack_q       <= '0;
    end else begin
      ack_q <= '0;
      if (accept && is_slide) begin
        busy_q      <= 1'b1;
        up_q        <= (cmd_i.op == cluster_pkg::CMD_SLIDE_UP);
        send_pend_q <= 1'b1;
        recv_done_q <= 1'b0;
      end else if (accept) begin
        // Every slice acks, only the addressed one acts
        ack_q.done <= 1'b1;
        if (hit && cmd_i.op == cluster_pkg::CMD_WRITE) elem_q <= cmd_i.data;
        if (hit && cmd_i.op == cluster_pkg::CMD_READ) ack_q.data <= elem_q;
      end else if (busy_q) begin
        if (send_fire) send_pend_q <= 1'b0;
        if (recv_fire) recv_done_q <= 1'b1;
        if (finish) begin
          busy_q     <= 1'b0;
          elem_q     <= rx_data;
          ack_q.done <= 1'b1;
        end
      end
    end
  end

  // Neighbour element parked until our own send is out
  always_ff @(posedge clk_i) begin
    if (recv_fire) rx_q <= rx_data;
  end

endmodule

//--- src/dispatch_ctrl.sv
////////////////////////////////////////
// Host command controller. Takes one command at a time,
// pushes it into the fork tree, gathers all cluster
// completions and returns a single response
////////////////////////////////////////

module dispatch_ctrl (
  input  logic                                          clk_i,
  input  logic                                          rst_i,
  input  logic                                          cmd_valid_i,
  input  cluster_pkg::cmd_t                             cmd_i,
  output logic                                          cmd_ready_o,
  output logic                                          rsp_valid_o,
  output cluster_pkg::rsp_t                             rsp_o,
  input  logic                                          rsp_ready_i,
  output logic                                          issue_valid_o,
  output cluster_pkg::cmd_t                             issue_cmd_o,
  input  logic                                          issue_ready_i,
  input  cluster_pkg::ack_t [cluster_pkg::NrClusters-1:0] ack_i
);

  cluster_pkg::ctrl_state_e state_q, state_d;
  cluster_pkg::cmd_t        cmd_q;
  cluster_pkg::elem_t       data_q;
  cluster_pkg::elem_t       ack_data;
  logic [cluster_pkg::NrClusters-1:0] done_q;
  logic [cluster_pkg::NrClusters-1:0] ack_done;
  logic                     cmd_accept;

  assign cmd_ready_o   = (state_q == cluster_pkg::ST_IDLE);
  assign cmd_accept    = cmd_valid_i && cmd_ready_o;
  assign issue_valid_o = (state_q == cluster_pkg::ST_ISSUE);
  assign issue_cmd_o   = cmd_q;
  assign rsp_valid_o   = (state_q == cluster_pkg::ST_RESP);
  assign rsp_o.data    = data_q;

  // Gather the per cluster done pulses and OR the returned data
  always_comb begin
    ack_done = '0;
    ack_data = '0;
    for (int i = 0; i < cluster_pkg::NrClusters; i++) begin
      ack_done[i] = ack_i[i].done;
      if (ack_i[i].done) begin
        ack_data = ack_data | ack_i[i].data;
      end
    end
  end

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      cluster_pkg::ST_IDLE:  if (cmd_valid_i) state_d = cluster_pkg::ST_ISSUE;
      cluster_pkg::ST_ISSUE: if (issue_ready_i) state_d = cluster_pkg::ST_WAIT;
      // All sticky bits set, response goes out next cycle
      cluster_pkg::ST_WAIT:  if (&done_q) state_d = cluster_pkg::ST_RESP;
      cluster_pkg::ST_RESP:  if (rsp_ready_i) state_d = cluster_pkg::ST_IDLE;
      default:               state_d = cluster_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= cluster_pkg::ST_IDLE;
      done_q  <= '0;
    end else begin
      state_q <= state_d;
      if (cmd_accept) begin
        done_q <= '0;
      end else begin
        done_q <= done_q | ack_done;
      end
    end
  end

  // Command and response payload
  always_ff @(posedge clk_i) begin
    if (cmd_accept) begin
      cmd_q  <= cmd_i;
      data_q <= '0;
    end else begin
      data_q <= data_q | ack_data;
    end
  end

endmodule

//--- src/cluster_system.sv
////////////////////////////////////////
// Top of the cluster slice system. Host port, controller,
// broadcast tree, four slices and the bidirectional ring
////////////////////////////////////////

module cluster_system (
  input  logic              clk_i,
  input  logic              rst_i,
  input  logic              cmd_valid_i,
  input  cluster_pkg::cmd_t cmd_i,
  output logic              cmd_ready_o,
  output logic              rsp_valid_o,
  output cluster_pkg::rsp_t rsp_o,
  input  logic              rsp_ready_i
);

  localparam int N = cluster_pkg::NrClusters;

  logic              issue_valid, issue_ready;
  cluster_pkg::cmd_t issue_cmd;

  logic [N-1:0]              leaf_valid, leaf_ready;
  cluster_pkg::cmd_t [N-1:0] leaf_cmd;
  cluster_pkg::ack_t [N-1:0] ack;

  // Slice side and spill side of each ring link
  logic               r_valid [N], r_ready [N], r_cut_valid [N], r_cut_ready [N];
  logic               l_valid [N], l_ready [N], l_cut_valid [N], l_cut_ready [N];
  cluster_pkg::elem_t r_data [N], r_cut_data [N], l_data [N], l_cut_data [N];

  dispatch_ctrl dispatch_ctrl_inst (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .cmd_ready_o   (cmd_ready_o),
    .rsp_valid_o   (rsp_valid_o),
    .rsp_o         (rsp_o),
    .rsp_ready_i   (rsp_ready_i),
    .issue_valid_o (issue_valid),
    .issue_cmd_o   (issue_cmd),
    .issue_ready_i (issue_ready),
    .ack_i         (ack)
  );

  req_fork_tree req_fork_tree_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (issue_valid),
    .cmd_i   (issue_cmd),
    .ready_o (issue_ready),
    .valid_o (leaf_valid),
    .cmd_o   (leaf_cmd),
    .ready_i (leaf_ready)
  );

  ////////////////////////////////////////
  // Slices and ring links
  ////////////////////////////////////////

  for (genvar i = 0; i < N; i++) begin : gen_cluster
    localparam int Prev = (i + N - 1) % N;
    localparam int Next = (i + 1) % N;

    vector_slice #(
      .ClusterId (cluster_pkg::cluster_id_t'(i))
    ) vector_slice_inst (
      .clk_i               (clk_i),
      .rst_i               (rst_i),
      .cmd_valid_i         (leaf_valid[i]),
      .cmd_i               (leaf_cmd[i]),
      .cmd_ready_o         (leaf_ready[i]),
      .ack_o               (ack[i]),
      .ring_r_valid_o      (r_valid[i]),
      .ring_r_o            (r_data[i]),
      .ring_r_ready_i      (r_ready[i]),
      .ring_l_valid_o      (l_valid[i]),
      .ring_l_o            (l_data[i]),
      .ring_l_ready_i      (l_ready[i]),
      // Left neighbour's right link, right neighbour's left link
      .ring_from_l_valid_i (r_cut_valid[Prev]),
      .ring_from_l_i       (r_cut_data[Prev]),
      .ring_from_l_ready_o (r_cut_ready[Prev]),
      .ring_from_r_valid_i (l_cut_valid[Next]),
      .ring_from_r_i       (l_cut_data[Next]),
      .ring_from_r_ready_o (l_cut_ready[Next])
    );

    ring_spill spill_r_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (r_valid[i]),
      .data_i  (r_data[i]),
      .ready_o (r_ready[i]),
      .valid_o (r_cut_valid[i]),
      .data_o  (r_cut_data[i]),
      .ready_i (r_cut_ready[i])
    );

    ring_spill spill_l_inst (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .valid_i (l_valid[i]),
      .data_i  (l_data[i]),
      .ready_o (l_ready[i]),
      .valid_o (l_cut_valid[i]),
      .data_o  (l_cut_data[i]),
      .ready_i (l_cut_ready[i])
    );
  end

endmodule

//--- test/tb_cluster_system.sv
////////////////////////////////////////
// Directed testbench for the cluster slice system.
// Runs host commands against a reference element model
////////////////////////////////////////

module tb_cluster_system;
  timeunit 1ns;
  timeprecision 1ps;

  // Commands over all tests, sizes the watchdog
  localparam int NrCmds = 66;

  logic               clk;
  logic               rst;
  logic               cmd_valid;
  logic               cmd_ready;
  logic               rsp_valid;
  logic               rsp_ready;
  cluster_pkg::cmd_t  cmd;
  cluster_pkg::rsp_t  rsp;
  cluster_pkg::elem_t model [cluster_pkg::NrClusters];
  int                 errors;
  integer             seed;

  cluster_system cluster_system_inst (
    .clk_i       (clk),
    .rst_i       (rst),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd),
    .cmd_ready_o (cmd_ready),
    .rsp_valid_o (rsp_valid),
    .rsp_o       (rsp),
    .rsp_ready_i (rsp_ready)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(NrCmds * 200 + 2000);
    $display("Timeout: the run did not finish within its time limit");
    $display("=== FAIL ===");
    $finish;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_rsp(input string what, input cluster_pkg::rsp_t exp,
                           input cluster_pkg::rsp_t act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %h got %h", $time, what, exp.data, act.data);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      errors++;
      $display("Mismatch at %0t: %s expected %b got %b", $time, what, exp, act);
    end
  endtask

  ////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////

  task automatic send_cmd(input cluster_pkg::cmd_t c);
    @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(negedge clk);
    while (!cmd_ready) @(negedge clk);
    // Transfer happens on this edge
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  task automatic get_rsp(input int delay, output cluster_pkg::rsp_t r);
    cluster_pkg::rsp_t held;
    @(negedge clk);
    while (!rsp_valid) @(negedge clk);
    held = rsp;
    repeat (delay) begin
      @(negedge clk);
      check_flag("rsp_valid_o while held", 1'b1, rsp_valid);
      check_flag("cmd_ready_o while response held", 1'b0, cmd_ready);
      check_rsp("rsp_o while held", held, rsp);
    end
    @(posedge clk);
    rsp_ready <= 1'b1;
    @(posedge clk);
    rsp_ready <= 1'b0;
    @(negedge clk);
    // One response per command
    check_flag("rsp_valid_o after handshake", 1'b0, rsp_valid);
    r = held;
  endtask

  // Update the model, send the command and compare its response
  task automatic run_cmd(input cluster_pkg::cmd_op_e op, input cluster_pkg::cluster_id_t id,
                         input cluster_pkg::elem_t data, input int delay);
    cluster_pkg::cmd_t  c;
    cluster_pkg::rsp_t  exp;
    cluster_pkg::rsp_t  got;
    cluster_pkg::elem_t old [cluster_pkg::NrClusters];
    c.op     = op;
    c.id     = id;
    c.data   = data;
    exp.data = '0;
    old      = model;
    case (op)
      cluster_pkg::CMD_WRITE: model[id] = data;
      cluster_pkg::CMD_READ:  exp.data = model[id];
      cluster_pkg::CMD_SLIDE_UP: begin
        for (int i = 0; i < cluster_pkg::NrClusters; i++) model[i] = old[(i + 3) % 4];
      end
      default: begin
        for (int i = 0; i < cluster_pkg::NrClusters; i++) model[i] = old[(i + 1) % 4];
      end
    endcase
    send_cmd(c);
    get_rsp(delay, got);
    check_rsp($sformatf("%s cluster %0d", op.name(), id), exp, got);
  endtask

  task automatic read_all(input int delay);
    for (int i = 0; i < cluster_pkg::NrClusters; i++) begin
      run_cmd(cluster_pkg::CMD_READ, cluster_pkg::cluster_id_t'(i), '0, delay);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk);
    check_flag("cmd_ready_o after reset", 1'b1, cmd_ready);
    check_flag("rsp_valid_o after reset", 1'b0, rsp_valid);
    read_all(0);
  endtask

  task automatic test_write_read();
    for (int i = 0; i < cluster_pkg::NrClusters; i++) begin
      run_cmd(cluster_pkg::CMD_WRITE, cluster_pkg::cluster_id_t'(i),
              cluster_pkg::elem_t'($random(seed)), 0);
    end
    read_all(0);
  endtask

  task automatic test_slide_up();
    run_cmd(cluster_pkg::CMD_SLIDE_UP, '0, '0, 0);
    read_all(0);
  endtask

  // Two down then two up must bring back the starting values
  task automatic test_slide_down();
    run_cmd(cluster_pkg::CMD_SLIDE_DOWN, '0, '0, 0);
    read_all(0);
    run_cmd(cluster_pkg::CMD_SLIDE_DOWN, '0, '0, 0);
    run_cmd(cluster_pkg::CMD_SLIDE_DOWN, '0, '0, 0);
    run_cmd(cluster_pkg::CMD_SLIDE_UP, '0, '0, 0);
    run_cmd(cluster_pkg::CMD_SLIDE_UP, '0, '0, 0);
    read_all(0);
  endtask

  task automatic test_backpressure();
    int delay;
    for (int n = 0; n < 6; n++) begin
      delay = 1 + ($unsigned($random(seed)) % 10);
      run_cmd(cluster_pkg::CMD_READ, cluster_pkg::cluster_id_t'(n % 4), '0, delay);
    end
  endtask

  task automatic test_random_mix();
    logic [31:0] r;
    for (int n = 0; n < 30; n++) begin
      r = $random(seed);
      run_cmd(cluster_pkg::cmd_op_e'(r[1:0]), cluster_pkg::cluster_id_t'(r[3:2]),
              cluster_pkg::elem_t'($random(seed)), 0);
    end
  endtask

  initial begin
    seed      = 74106;
    errors    = 0;
    rst       = 1'b1;
    cmd_valid = 1'b0;
    cmd       = '0;
    rsp_ready = 1'b0;
    for (int i = 0; i < cluster_pkg::NrClusters; i++) model[i] = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_reset_state();
    test_write_read();
    test_slide_up();
    test_slide_down();
    test_backpressure();
    test_random_mix();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

//--- flist.f
src/cluster_pkg.sv
src/ring_spill.sv
src/req_fork_tree.sv
src/vector_slice.sv
src/dispatch_ctrl.sv
src/cluster_system.sv
test/tb_cluster_system.sv
